// File: src/regfile_pkg.sv
/*
 * Shared widths and types for the operand stage.
 * Every module imports this package for data, register index and ID types.
 */

package regfile_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////////////////////

    // Integer data width
    localparam int XLEN = 32;

    // Architectural registers, x0 hardwired to zero
    localparam int NUM_REGS = 32;
    localparam int REG_ADDR_W = 5;

    // Instruction ID doubles as the writeback buffer slot index
    localparam int ID_W = 3;
    localparam int NUM_IDS = 8;

    // Occupancy count must hold 0 through NUM_IDS
    localparam int CNT_W = ID_W + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // Register value or execution result
    typedef logic [XLEN-1:0] data_t;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [ID_W-1:0] inst_id_t;

endpackage

// File: src/id_inuse.sv
/*
 * Per-register pending bits and the ID of each register's youngest writer.
 * Set on issue, released on retirement of the matching writer.
 */

`timescale 1ns/100ps

module id_inuse (
    input  logic                   clk,
    input  logic                   reset,
    input  regfile_pkg::reg_addr_t rs1_addr,
    input  regfile_pkg::reg_addr_t rs2_addr,
    input  logic                   issued,
    input  regfile_pkg::reg_addr_t issued_rd_addr,
    input  regfile_pkg::inst_id_t  issue_id,
    input  logic                   retired,
    input  regfile_pkg::reg_addr_t retired_rd,
    input  regfile_pkg::inst_id_t  retired_id,
    output logic                   rs1_inuse,
    output logic                   rs2_inuse,
    output regfile_pkg::inst_id_t  rs1_id,
    output regfile_pkg::inst_id_t  rs2_id
);
    import regfile_pkg::*;

    // One pending bit per register
    logic [NUM_REGS-1:0] inuse;

    // Youngest writer of each register
    inst_id_t inuse_by [NUM_REGS];

    logic issue_claims;
    logic retire_releases;

    // x0 is never claimed
    assign issue_claims = issued && (issued_rd_addr != '0);

    // Only the recorded writer may release its register
    assign retire_releases = retired && (inuse_by[retired_rd] == retired_id);

    always_ff @(posedge clk) begin
        if (reset) begin
            inuse <= '0;
        end else begin
            if (retire_releases)
                inuse[retired_rd] <= 1'b0;
            // Issue overrides a release of the same register
            if (issue_claims)
                inuse[issued_rd_addr] <= 1'b1;
        end
    end

    // Writer table
    always_ff @(posedge clk) begin
        if (issue_claims)
            inuse_by[issued_rd_addr] <= issue_id;
    end

    // Combinational source lookups
    assign rs1_inuse = inuse[rs1_addr];
    assign rs2_inuse = inuse[rs2_addr];
    assign rs1_id = inuse_by[rs1_addr];
    assign rs2_id = inuse_by[rs2_addr];

endmodule

// File: src/writeback_buffer.sv
/*
 * Circular writeback buffer indexed by instruction ID.
 * Allocates IDs at issue, takes results in any order, retires in issue order
 * and serves forwarding lookups for pending sources.
 */

`timescale 1ns/100ps

module writeback_buffer (
    input  logic                   clk,
    input  logic                   reset,
    // Issue side
    input  logic                   issue,
    input  regfile_pkg::reg_addr_t issue_rd,
    output regfile_pkg::inst_id_t  issue_id,
    output logic                   issue_ready,
    // Completion from execution units
    input  logic                   complete,
    input  regfile_pkg::inst_id_t  complete_id,
    input  regfile_pkg::data_t     complete_data,
    // Forwarding lookups
    input  regfile_pkg::inst_id_t  rs1_id,
    input  regfile_pkg::inst_id_t  rs2_id,
    output regfile_pkg::data_t     rs1_fwd_data,
    output regfile_pkg::data_t     rs2_fwd_data,
    output logic                   rs1_fwd_valid,
    output logic                   rs2_fwd_valid,
    // In-order retirement
    output logic                   retired,
    output regfile_pkg::inst_id_t  retired_id,
    output regfile_pkg::reg_addr_t retired_rd,
    output regfile_pkg::data_t     retired_data
);
    import regfile_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Slot storage
    ////////////////////////////////////////////////////////////////////////////

    reg_addr_t slot_rd   [NUM_IDS];
    data_t     slot_data [NUM_IDS];

    // Result present, cleared when the slot is allocated or freed
    logic [NUM_IDS-1:0] slot_done;

    // Oldest outstanding entry and next free slot
    inst_id_t head;
    inst_id_t tail;

    logic [CNT_W-1:0] count;

    logic alloc;

    // Full buffer ignores issue
    assign issue_ready = (count != CNT_W'(NUM_IDS));
    assign alloc = issue && issue_ready;
    assign issue_id = tail;

    // Head retires as soon as its result is in
    assign retired = slot_done[head];
    assign retired_id = head;
    assign retired_rd = slot_rd[head];
    assign retired_data = slot_data[head];

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            // ID width covers NUM_IDS, pointers wrap on their own
            if (alloc)
                tail <= tail + 1'b1;
            if (retired)
                head <= head + 1'b1;
            count <= count + CNT_W'(alloc) - CNT_W'(retired);
        end
    end

    // Done bits
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_done <= '0;
        end else begin
            if (retired)
                slot_done[head] <= 1'b0;
            if (complete)
                slot_done[complete_id] <= 1'b1;
            if (alloc)
                slot_done[tail] <= 1'b0;
        end
    end

    // Payload, written on allocation and completion
    always_ff @(posedge clk) begin
        if (alloc)
            slot_rd[tail] <= issue_rd;
        if (complete)
            slot_data[complete_id] <= complete_data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding by ID
    ////////////////////////////////////////////////////////////////////////////

    assign rs1_fwd_data = slot_data[rs1_id];
    assign rs2_fwd_data = slot_data[rs2_id];
    assign rs1_fwd_valid = slot_done[rs1_id];
    assign rs2_fwd_valid = slot_done[rs2_id];

endmodule

// File: src/register_file.sv
/*
 * Architectural register file with pending-writer tracking.
 * Picks stored or forwarded operands and flags sources still being computed.
 */

`timescale 1ns/100ps

module register_file (
    input  logic                   clk,
    input  logic                   reset,
    // Decode side
    input  regfile_pkg::reg_addr_t rs1_addr,
    input  regfile_pkg::reg_addr_t rs2_addr,
    input  logic                   uses_rs1,
    input  logic                   uses_rs2,
    input  logic                   issue,
    input  regfile_pkg::reg_addr_t rd_addr,
    input  regfile_pkg::inst_id_t  issue_id,
    // Retirement from the writeback buffer
    input  logic                   retired,
    input  regfile_pkg::inst_id_t  retired_id,
    input  regfile_pkg::reg_addr_t retired_rd,
    input  regfile_pkg::data_t     retired_data,
    // Forwarding lookups
    output regfile_pkg::inst_id_t  rs1_id,
    output regfile_pkg::inst_id_t  rs2_id,
    input  regfile_pkg::data_t     rs1_fwd_data,
    input  regfile_pkg::data_t     rs2_fwd_data,
    input  logic                   rs1_fwd_valid,
    input  logic                   rs2_fwd_valid,
    // Operands
    output regfile_pkg::data_t     rs1_data,
    output regfile_pkg::data_t     rs2_data,
    output logic                   rs1_conflict,
    output logic                   rs2_conflict
);
    import regfile_pkg::*;

    data_t regs [NUM_REGS];

    logic rs1_inuse;
    logic rs2_inuse;
    logic write_en;

    // x0 is never written and keeps its reset value of zero
    assign write_en = retired && (retired_rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (write_en) begin
            regs[retired_rd] <= retired_data;
        end
    end

    id_inuse inuse_mem (
        .clk            (clk),
        .reset          (reset),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .issued         (issue),
        .issued_rd_addr (rd_addr),
        .issue_id       (issue_id),
        .retired        (retired),
        .retired_rd     (retired_rd),
        .retired_id     (retired_id),
        .rs1_inuse      (rs1_inuse),
        .rs2_inuse      (rs2_inuse),
        .rs1_id         (rs1_id),
        .rs2_id         (rs2_id)
    );

    // Pending source takes the buffer result
    assign rs1_data = rs1_inuse ? rs1_fwd_data : regs[rs1_addr];
    assign rs2_data = rs2_inuse ? rs2_fwd_data : regs[rs2_addr];

    // Conflict only for a used source whose writer has no result yet
    assign rs1_conflict = uses_rs1 && rs1_inuse && !rs1_fwd_valid;
    assign rs2_conflict = uses_rs2 && rs2_inuse && !rs2_fwd_valid;

endmodule

// File: src/operand_stage.sv
/*
 * Operand stage top level.
 * Joins the register file and the writeback buffer.
 */

`timescale 1ns/100ps

module operand_stage (
    input  logic                   clk,
    input  logic                   reset,
    // Issue
    input  regfile_pkg::reg_addr_t rs1_addr,
    input  regfile_pkg::reg_addr_t rs2_addr,
    input  logic                   uses_rs1,
    input  logic                   uses_rs2,
    input  regfile_pkg::reg_addr_t rd_addr,
    input  logic                   issue,
    output regfile_pkg::inst_id_t  issue_id,
    output logic                   issue_ready,
    output regfile_pkg::data_t     rs1_data,
    output regfile_pkg::data_t     rs2_data,
    output logic                   rs1_conflict,
    output logic                   rs2_conflict,
    // Completion
    input  logic                   complete,
    input  regfile_pkg::inst_id_t  complete_id,
    input  regfile_pkg::data_t     complete_data,
    // Retirement
    output logic                   retired,
    output regfile_pkg::reg_addr_t retired_rd,
    output regfile_pkg::data_t     retired_data
);
    import regfile_pkg::*;

    inst_id_t retired_id;
    inst_id_t rs1_id;
    inst_id_t rs2_id;
    data_t    rs1_fwd_data;
    data_t    rs2_fwd_data;
    logic     rs1_fwd_valid;
    logic     rs2_fwd_valid;

    // Only an accepted issue may claim a register
    logic     issue_accepted;

    assign issue_accepted = issue && issue_ready;

    register_file rf0 (
        .clk (clk), .reset (reset),
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
        .uses_rs1 (uses_rs1), .uses_rs2 (uses_rs2),
        .issue (issue_accepted), .rd_addr (rd_addr), .issue_id (issue_id),
        .retired (retired), .retired_id (retired_id),
        .retired_rd (retired_rd), .retired_data (retired_data),
        .rs1_id (rs1_id), .rs2_id (rs2_id),
        .rs1_fwd_data (rs1_fwd_data), .rs2_fwd_data (rs2_fwd_data),
        .rs1_fwd_valid (rs1_fwd_valid), .rs2_fwd_valid (rs2_fwd_valid),
        .rs1_data (rs1_data), .rs2_data (rs2_data),
        .rs1_conflict (rs1_conflict), .rs2_conflict (rs2_conflict)
    );

    writeback_buffer wb0 (
        .clk (clk), .reset (reset),
        .issue (issue), .issue_rd (rd_addr),
        .issue_id (issue_id), .issue_ready (issue_ready),
        .complete (complete), .complete_id (complete_id), .complete_data (complete_data),
        .rs1_id (rs1_id), .rs2_id (rs2_id),
        .rs1_fwd_data (rs1_fwd_data), .rs2_fwd_data (rs2_fwd_data),
        .rs1_fwd_valid (rs1_fwd_valid), .rs2_fwd_valid (rs2_fwd_valid),
        .retired (retired), .retired_id (retired_id),
        .retired_rd (retired_rd), .retired_data (retired_data)
    );

endmodule

// File: bench/operand_ref.svh
/*
 * Reference model for the operand stage testbench.
 * Included inside the testbench module, after the package import.
 */

`ifndef OPERAND_REF_SVH
`define OPERAND_REF_SVH

// One outstanding instruction in issue order
typedef struct {
    inst_id_t  id;
    reg_addr_t rd;
    logic      done;
    data_t     data;
} ref_entry_t;

data_t      ref_regs [NUM_REGS];
ref_entry_t ref_queue [$];
inst_id_t   ref_next_id;

function automatic void clear_model();
    foreach (ref_regs[i])
        ref_regs[i] = '0;
    ref_queue.delete();
    ref_next_id = '0;
endfunction

// Expected operand and conflict for one source
// Known is low while the writer is still computing
function automatic void expected_operand(input reg_addr_t src, input logic uses,
                                         output data_t data, output logic conflict,
                                         output logic known);
    data = ref_regs[src];
    conflict = 1'b0;
    known = 1'b1;
    // Last match in issue order is the youngest writer
    if (src != '0) begin
        foreach (ref_queue[i]) begin
            if (ref_queue[i].rd == src) begin
                data = ref_queue[i].data;
                known = ref_queue[i].done;
                conflict = uses && !ref_queue[i].done;
            end
        end
    end
endfunction

// Oldest entry leaves once its result is in
function automatic logic retire_due();
    return (ref_queue.size() != 0) && ref_queue[0].done;
endfunction

// Advance the model across one clock edge
function automatic void step_model(input logic do_issue, input reg_addr_t rd,
                                   input logic do_complete, input inst_id_t cid,
                                   input data_t cdata);
    logic       accept;
    ref_entry_t entry;
    accept = do_issue && (ref_queue.size() < NUM_IDS);
    if (retire_due()) begin
        if (ref_queue[0].rd != '0)
            ref_regs[ref_queue[0].rd] = ref_queue[0].data;
        void'(ref_queue.pop_front());
    end
    if (do_complete) begin
        foreach (ref_queue[i]) begin
            if (ref_queue[i].id == cid) begin
                ref_queue[i].done = 1'b1;
                ref_queue[i].data = cdata;
            end
        end
    end
    if (accept) begin
        entry.id = ref_next_id;
        entry.rd = rd;
        entry.done = 1'b0;
        entry.data = '0;
        ref_queue.push_back(entry);
        ref_next_id = ref_next_id + 1'b1;
    end
endfunction

`endif

// File: bench/operand_stage_tb.sv
/*
 * Testbench for the operand stage.
 * Drives issue and completion traffic and checks every cycle against the model.
 */

`timescale 1ns/100ps

module operand_stage_tb;
    import regfile_pkg::*;

    `include "operand_ref.svh"

    logic      clk;
    logic      reset;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      uses_rs1;
    logic      uses_rs2;
    reg_addr_t rd_addr;
    logic      issue;
    inst_id_t  issue_id;
    logic      issue_ready;
    data_t     rs1_data;
    data_t     rs2_data;
    logic      rs1_conflict;
    logic      rs2_conflict;
    logic      complete;
    inst_id_t  complete_id;
    data_t     complete_data;
    logic      retired;
    reg_addr_t retired_rd;
    data_t     retired_data;

    // Expected operands of the current cycle
    data_t exp1_data;
    data_t exp2_data;
    logic  exp1_conflict;
    logic  exp2_conflict;
    logic  exp1_known;
    logic  exp2_known;

    // Accepted issues not yet retired by the DUT
    int dut_pending = 0;

    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int errors_at_start = 0;

    operand_stage dut0 (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_id(input string name, input inst_id_t got, input inst_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_retire(input reg_addr_t got_rd, input data_t got_data,
                                input reg_addr_t exp_rd, input data_t exp_data);
        checks++;
        if (got_rd !== exp_rd || got_data !== exp_data) begin
            errors++;
            $display("MISMATCH retired_rd/retired_data got %h/%h expected %h/%h at %0t",
                     got_rd, got_data, exp_rd, exp_data, $time);
        end
    endtask

    // Outputs are settled mid-cycle
    // The model then takes this cycle's edge
    always @(negedge clk) begin
        if (!reset) begin
            expected_operand(rs1_addr, uses_rs1, exp1_data, exp1_conflict, exp1_known);
            expected_operand(rs2_addr, uses_rs2, exp2_data, exp2_conflict, exp2_known);
            check_flag("rs1_conflict", rs1_conflict, exp1_conflict);
            check_flag("rs2_conflict", rs2_conflict, exp2_conflict);
            if (exp1_known)
                check_data("rs1_data", rs1_data, exp1_data);
            if (exp2_known)
                check_data("rs2_data", rs2_data, exp2_data);
            check_flag("issue_ready", issue_ready, logic'(ref_queue.size() < NUM_IDS));
            check_id("issue_id", issue_id, ref_next_id);
            check_flag("retired", retired, retire_due());
            if (retired && retire_due())
                check_retire(retired_rd, retired_data, ref_queue[0].rd, ref_queue[0].data);
            // DUT side occupancy from its own strobes
            if (issue && issue_ready)
                dut_pending++;
            if (retired)
                dut_pending--;
            step_model(issue, rd_addr, complete, complete_id, complete_data);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic issue_write(input reg_addr_t rd);
        @(posedge clk);
        issue <= 1'b1;
        rd_addr <= rd;
        complete <= 1'b0;
    endtask

    task automatic read_regs(input reg_addr_t a, input reg_addr_t b,
                             input logic u1, input logic u2);
        @(posedge clk);
        issue <= 1'b0;
        complete <= 1'b0;
        rs1_addr <= a;
        rs2_addr <= b;
        uses_rs1 <= u1;
        uses_rs2 <= u2;
    endtask

    // Mode 0 oldest, 1 youngest, otherwise random among unfinished entries
    task automatic complete_pick(input int mode);
        int idx [$];
        int pick;
        @(posedge clk);
        issue <= 1'b0;
        complete <= 1'b0;
        foreach (ref_queue[i])
            if (!ref_queue[i].done)
                idx.push_back(i);
        if (idx.size() != 0) begin
            if (mode == 0)
                pick = idx[0];
            else if (mode == 1)
                pick = idx[idx.size()-1];
            else
                pick = idx[$urandom % idx.size()];
            complete <= 1'b1;
            complete_id <= ref_queue[pick].id;
            complete_data <= $urandom;
        end
    endtask

    // Idle until the DUT has retired every accepted issue
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((ref_queue.size() != 0 || dut_pending != 0) && n < limit) begin
            @(posedge clk);
            issue <= 1'b0;
            complete <= 1'b0;
            n++;
        end
        if (ref_queue.size() != 0 || dut_pending != 0) begin
            errors++;
            $display("Timeout: retirement not finished after %0d cycles, %0d left in the DUT",
                     limit, dut_pending);
        end
    endtask

    task automatic drain_random(input int limit);
        int n;
        n = 0;
        while (ref_queue.size() != 0 && n < limit) begin
            complete_pick(2);
            n++;
        end
        wait_drain(limit);
    endtask

    task automatic end_test(input string name);
        // Let the compare process see the last cycle of the test
        @(posedge clk);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAILED with %0d errors", tests_run, name,
                     errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'he292c452));
        clk = 1'b0;
        reset = 1'b1;
        rs1_addr = '0;
        rs2_addr = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        rd_addr = '0;
        issue = 1'b0;
        complete = 1'b0;
        complete_id = '0;
        complete_data = '0;
        clear_model();
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < NUM_REGS; i++)
            read_regs(reg_addr_t'(i), reg_addr_t'(NUM_REGS-1-i), 1'b1, 1'b1);
        end_test("reset state");

        for (int i = 1; i <= 6; i++)
            issue_write(reg_addr_t'(i));
        drain_random(40);
        for (int i = 1; i <= 6; i++)
            read_regs(reg_addr_t'(i), reg_addr_t'(7-i), 1'b1, 1'b1);
        end_test("random completion order");

        // Younger writer finishes first and forwards while the older blocks retire
        issue_write(5'd5);
        issue_write(5'd6);
        read_regs(5'd6, 5'd5, 1'b1, 1'b0);
        read_regs(5'd6, 5'd5, 1'b1, 1'b0);
        complete_pick(1);
        read_regs(5'd6, 5'd5, 1'b1, 1'b0);
        read_regs(5'd6, 5'd6, 1'b0, 1'b1);
        complete_pick(0);
        wait_drain(20);
        read_regs(5'd5, 5'd6, 1'b1, 1'b1);
        end_test("conflict and forwarding");

        issue_write(5'd9);
        issue_write(5'd9);
        read_regs(5'd9, 5'd9, 1'b1, 1'b0);
        complete_pick(0);
        read_regs(5'd9, 5'd9, 1'b1, 1'b1);
        read_regs(5'd9, 5'd9, 1'b1, 1'b1);
        complete_pick(1);
        wait_drain(20);
        read_regs(5'd9, 5'd0, 1'b1, 1'b1);
        end_test("same destination twice");

        issue_write(5'd0);
        issue_write(5'd7);
        issue_write(5'd0);
        read_regs(5'd0, 5'd7, 1'b1, 1'b1);
        drain_random(40);
        read_regs(5'd0, 5'd7, 1'b1, 1'b1);
        end_test("writes to x0");

        // Fill every slot, then try once more while full
        for (int i = 0; i < NUM_IDS; i++)
            issue_write(reg_addr_t'(10 + i));
        issue_write(5'd20);
        read_regs(5'd10, 5'd20, 1'b1, 1'b1);
        drain_random(60);
        issue_write(5'd21);
        drain_random(20);
        read_regs(5'd20, 5'd21, 1'b1, 1'b1);
        end_test("full buffer back-pressure");

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Overall limit on run time
    initial begin
        #100000;
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+bench
src/regfile_pkg.sv
src/id_inuse.sv
src/writeback_buffer.sv
src/register_file.sv
src/operand_stage.sv
bench/operand_stage_tb.sv

// File: Bender.yml
package:
  name: operand_stage

sources:
  - files:
      - src/regfile_pkg.sv
      - src/id_inuse.sv
      - src/writeback_buffer.sv
      - src/register_file.sv
      - src/operand_stage.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/operand_stage_tb.sv
